// File: linkq.f
+incdir+tests
design/lq_pkg.sv
design/lq_link_ram.sv
design/lq_queue_state.sv
design/lq_queue_engine.sv
design/lq_top.sv
tests/lq_tb.sv

// File: tests/lq_tb_tasks.svh
`ifndef LQ_TB_TASKS_SVH
`define LQ_TB_TASKS_SVH

// Every queue is empty right after reset
task automatic empty_pops();
  cur_test = "empty_pop";
  for (int q = 0; q < NUM_QUEUES; q++) begin
    run_cycle(1'b0, 0, 1'b1, q);
  end
  run_cycle(1'b0, 0, 1'b1, NUM_QUEUES - 1);  // Same queue twice in a row
endtask

task automatic fifo_order();
  cur_test = "fifo_order";
  repeat (10) begin
    run_cycle(1'b1, 3, 1'b0, 0);
  end
  repeat (10) begin
    run_cycle(1'b0, 0, 1'b1, 3);
  end
  run_cycle(1'b0, 0, 1'b1, 3);  // Now empty
  read_queue_state(3);
endtask

task automatic independent_queues();
  int order [$];
  cur_test = "independent_queues";
  for (int r = 0; r < 4; r++) begin
    for (int q = 0; q < NUM_QUEUES; q++) begin
      run_cycle(1'b1, q, 1'b0, 0);
      order.push_back(q);
    end
  end
  shuffle_list(order);
  foreach (order[i]) begin
    run_cycle(1'b0, 0, 1'b1, order[i]);
  end
  for (int q = 0; q < NUM_QUEUES; q++) begin
    read_queue_state(q);
  end
endtask

task automatic back_to_back();
  cur_test = "back_to_back";
  repeat (6) begin
    run_cycle(1'b1, 1, 1'b0, 0);
  end
  repeat (3) begin
    run_cycle(1'b0, 0, 1'b1, 1);
  end
  run_cycle(1'b1, 1, 1'b1, 1);  // Count 3
  repeat (2) begin
    run_cycle(1'b0, 0, 1'b1, 1);
  end
  // Count 1 puts link write and read on one address
  run_cycle(1'b1, 1, 1'b1, 1);
  run_cycle(1'b1, 1, 1'b1, 1);
  run_cycle(1'b0, 0, 1'b1, 1);
  // Count 0 right after the drain and after a quiet cycle
  run_cycle(1'b1, 1, 1'b1, 1);
  run_cycle(1'b0, 0, 1'b1, 1);
  idle_cycle();
  run_cycle(1'b1, 1, 1'b1, 1);
  read_queue_state(1);
  // Different queues in one cycle
  run_cycle(1'b1, 5, 1'b1, 1);
  run_cycle(1'b1, 5, 1'b1, 5);
  drain_queue(1);
  drain_queue(5);
  read_queue_state(5);
endtask

task automatic cpu_access();
  cur_test = "cpu_access";
  repeat (3) begin
    run_cycle(1'b1, 6, 1'b0, 0);
  end
  repeat (2) begin
    run_cycle(1'b1, 2, 1'b0, 0);
  end
  for (int q = 0; q < NUM_QUEUES; q++) begin
    read_queue_state(q);
  end
  clear_queue_by_cpu(2, 42, 17);
  read_queue_state(2);
  run_cycle(1'b0, 0, 1'b1, 2);  // Emptied by the CPU
  run_cycle(1'b1, 2, 1'b0, 0);
  run_cycle(1'b1, 2, 1'b0, 0);
  read_queue_state(2);
  drain_queue(2);
  drain_queue(6);
  read_queue_state(2);
  read_queue_state(6);
endtask

`endif

// File: tests/lq_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lq_tb
  import lq_pkg::*;
();

  localparam int NUM_QUEUES      = NUM_QUEUES_MAX;
  localparam int NUM_PTRS        = NUM_PTRS_MAX;
  localparam int SEED            = 32'hdc12;
  localparam int TEST_CYCLES     = 200;  // Rough length of all tests together
  localparam int WATCHDOG_CYCLES = 10 * TEST_CYCLES;

  logic         clk;
  logic         reset;
  logic         push;
  push_req_t    pu_req;
  logic         pu_cvld;
  push_rsp_t    pu_rsp;
  logic         pop;
  pop_req_t     po_req;
  logic         po_cvld;
  pop_rsp_t     po_rsp;
  logic         cp_read;
  logic         cp_write;
  qid_t         cp_adr;
  queue_state_t cp_din;
  logic         cp_vld;
  queue_state_t cp_dout;

  // Reference model, one queue of pointers per DUT queue
  int    mdl_q [NUM_QUEUES][$];
  int    last_head [NUM_QUEUES];
  int    last_tail [NUM_QUEUES];
  int    free_ptrs [$];  // Pointers not held by any queue

  int    errors;
  int    checks;
  string cur_test;

  lq_top #(
    .NUM_QUEUES (NUM_QUEUES),
    .NUM_PTRS   (NUM_PTRS)
  ) dut_i (
    .clk      (clk),
    .reset    (reset),
    .push     (push),
    .pu_req   (pu_req),
    .pu_cvld  (pu_cvld),
    .pu_rsp   (pu_rsp),
    .pop      (pop),
    .po_req   (po_req),
    .po_cvld  (po_cvld),
    .po_rsp   (po_rsp),
    .cp_read  (cp_read),
    .cp_write (cp_write),
    .cp_adr   (cp_adr),
    .cp_din   (cp_din),
    .cp_vld   (cp_vld),
    .cp_dout  (cp_dout)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, the test sequence did not complete", WATCHDOG_CYCLES);
    $display("Finished with errors");
    $finish;
  end

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("Fail %s: %s expected %0d, actual %0d", cur_test, what, exp, act);
    end
  endtask

  task automatic shuffle_list(ref int list [$]);
    int j;
    int tmp;
    for (int i = list.size() - 1; i > 0; i--) begin
      j       = $urandom_range(i, 0);
      tmp     = list[i];
      list[i] = list[j];
      list[j] = tmp;
    end
  endtask

  // One cycle with no requests, all response strobes low afterwards
  task automatic idle_cycle();
    push     = 1'b0;
    pop      = 1'b0;
    cp_read  = 1'b0;
    cp_write = 1'b0;
    @(posedge clk);
    #1;
    check_eq("pu_cvld when idle", 0, pu_cvld);
    check_eq("po_cvld when idle", 0, po_cvld);
    check_eq("cp_vld when idle", 0, cp_vld);
  endtask

  // Optional push and pop in one cycle, checked one cycle later
  task automatic run_cycle(input bit do_push, input int pu_q, input bit do_pop, input int po_q);
    int   new_ptr;
    int   pu_size;
    int   po_size;
    bit   exp_pvld;
    int   exp_ptr;
    int   exp_prev_tail;
    pu_size       = mdl_q[pu_q].size();
    po_size       = mdl_q[po_q].size();
    exp_pvld      = (po_size != 0);
    exp_ptr       = exp_pvld ? mdl_q[po_q][0] : 0;
    exp_prev_tail = last_tail[pu_q];
    new_ptr       = 0;
    if (do_push) begin
      assert (free_ptrs.size() != 0) else begin
        errors++;
        $display("Pointer pool is empty in %s, the push reuses pointer 0", cur_test);
      end
      if (free_ptrs.size() != 0) begin
        new_ptr = free_ptrs.pop_front();
      end
    end
    push       = do_push;
    pu_req.qid = qid_t'(pu_q);
    pu_req.ptr = ptr_t'(new_ptr);
    pop        = do_pop;
    po_req.qid = qid_t'(po_q);
    @(posedge clk);
    #1;
    push = 1'b0;
    pop  = 1'b0;
    check_eq("pu_cvld", do_push, pu_cvld);
    check_eq("po_cvld", do_pop, po_cvld);
    check_eq("cp_vld", 0, cp_vld);
    if (do_push) begin
      check_eq("pu_rsp.cnt", pu_size + 1, pu_rsp.cnt);
      check_eq("pu_rsp.tail", exp_prev_tail, pu_rsp.tail);
    end
    if (do_pop) begin
      check_eq("po_rsp.pvld", exp_pvld, po_rsp.pvld);
      check_eq("po_rsp.cnt", po_size, po_rsp.cnt);
      if (exp_pvld) begin
        check_eq("po_rsp.ptr", exp_ptr, po_rsp.ptr);
      end
    end
    // The pop sees the state before a same-cycle push
    if (do_pop && exp_pvld) begin
      void'(mdl_q[po_q].pop_front());
      free_ptrs.push_back(exp_ptr);
      last_head[po_q] = (mdl_q[po_q].size() != 0) ? mdl_q[po_q][0] : last_tail[po_q];
    end
    if (do_push) begin
      if (mdl_q[pu_q].size() == 0) begin
        last_head[pu_q] = new_ptr;
      end
      mdl_q[pu_q].push_back(new_ptr);
      last_tail[pu_q] = new_ptr;
    end
  endtask

  task automatic drain_queue(input int q);
    while (mdl_q[q].size() != 0) begin
      run_cycle(1'b0, 0, 1'b1, q);
    end
  endtask

  // Idle first so a pending pop head is committed
  task automatic read_queue_state(input int q);
    idle_cycle();
    cp_read = 1'b1;
    cp_adr  = qid_t'(q);
    @(posedge clk);
    #1;
    cp_read = 1'b0;
    check_eq("cp_vld", 1, cp_vld);
    check_eq("cp_dout.head", last_head[q], cp_dout.head);
    check_eq("cp_dout.tail", last_tail[q], cp_dout.tail);
    check_eq("cp_dout.count", mdl_q[q].size(), cp_dout.count);
  endtask

  task automatic clear_queue_by_cpu(input int q, input int head, input int tail);
    idle_cycle();
    cp_write    = 1'b1;
    cp_adr      = qid_t'(q);
    cp_din.head  = ptr_t'(head);
    cp_din.tail  = ptr_t'(tail);
    cp_din.count = '0;
    @(posedge clk);
    #1;
    cp_write = 1'b0;
    check_eq("cp_vld after write", 0, cp_vld);
    while (mdl_q[q].size() != 0) begin
      free_ptrs.push_back(mdl_q[q].pop_front());
    end
    last_head[q] = head;
    last_tail[q] = tail;
  endtask

`include "lq_tb_tasks.svh"

  initial begin
    push     = 1'b0;
    pu_req   = '0;
    pop      = 1'b0;
    po_req   = '0;
    cp_read  = 1'b0;
    cp_write = 1'b0;
    cp_adr   = '0;
    cp_din   = '0;
    reset    = 1'b1;
    errors   = 0;
    checks   = 0;
    cur_test = "reset";
    void'($urandom(SEED));
    for (int i = 0; i < NUM_QUEUES; i++) begin
      last_head[i] = 0;
      last_tail[i] = 0;
    end
    for (int i = 0; i < NUM_PTRS; i++) begin
      free_ptrs.push_back(i);
    end
    shuffle_list(free_ptrs);

    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    check_eq("pu_cvld after reset", 0, pu_cvld);
    check_eq("po_cvld after reset", 0, po_cvld);
    check_eq("cp_vld after reset", 0, cp_vld);

    empty_pops();
    fifo_order();
    independent_queues();
    back_to_back();
    cpu_access();
    idle_cycle();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/lq_top.sv
`timescale 1ns/1ps
`default_nettype none

// Linked-list queue manager
module lq_top
  import lq_pkg::*;
#(
  parameter int NUM_QUEUES = NUM_QUEUES_MAX,
  parameter int NUM_PTRS   = NUM_PTRS_MAX
) (
  input  wire          clk,
  input  wire          reset,

  input  wire          push,
  input  push_req_t    pu_req,
  output logic         pu_cvld,
  output push_rsp_t    pu_rsp,

  input  wire          pop,
  input  pop_req_t     po_req,
  output logic         po_cvld,
  output pop_rsp_t     po_rsp,

  input  wire          cp_read,
  input  wire          cp_write,
  input  qid_t         cp_adr,
  input  queue_state_t cp_din,
  output logic         cp_vld,
  output queue_state_t cp_dout
);

  qid_t         pu_qid;
  qid_t         po_qid;
  queue_state_t pu_state;
  queue_state_t po_state;
  logic         pu_upd;
  qid_t         pu_upd_qid;
  queue_state_t pu_upd_state;
  logic         po_upd;
  qid_t         po_upd_qid;
  queue_state_t po_upd_state;

  logic         wr_en;
  ptr_t         wr_adr;
  ptr_t         wr_data;
  logic         rd_en;
  ptr_t         rd_adr;
  ptr_t         rd_data;

  lq_queue_engine engine_i (
    .clk          (clk),
    .reset        (reset),
    .push         (push),
    .pu_req       (pu_req),
    .pop          (pop),
    .po_req       (po_req),
    .pu_qid       (pu_qid),
    .po_qid       (po_qid),
    .pu_state     (pu_state),
    .po_state     (po_state),
    .pu_upd       (pu_upd),
    .pu_upd_qid   (pu_upd_qid),
    .pu_upd_state (pu_upd_state),
    .po_upd       (po_upd),
    .po_upd_qid   (po_upd_qid),
    .po_upd_state (po_upd_state),
    .wr_en        (wr_en),
    .wr_adr       (wr_adr),
    .wr_data      (wr_data),
    .rd_en        (rd_en),
    .rd_adr       (rd_adr),
    .rd_data      (rd_data),
    .pu_cvld      (pu_cvld),
    .pu_rsp       (pu_rsp),
    .po_cvld      (po_cvld),
    .po_rsp       (po_rsp)
  );

  lq_queue_state #(
    .NUM_QUEUES (NUM_QUEUES),
    .NUM_PTRS   (NUM_PTRS)
  ) state_i (
    .clk          (clk),
    .reset        (reset),
    .pu_qid       (pu_qid),
    .po_qid       (po_qid),
    .pu_state     (pu_state),
    .po_state     (po_state),
    .pu_upd       (pu_upd),
    .pu_upd_qid   (pu_upd_qid),
    .pu_upd_state (pu_upd_state),
    .po_upd       (po_upd),
    .po_upd_qid   (po_upd_qid),
    .po_upd_state (po_upd_state),
    .cp_read      (cp_read),
    .cp_write     (cp_write),
    .cp_adr       (cp_adr),
    .cp_din       (cp_din),
    .cp_vld       (cp_vld),
    .cp_dout      (cp_dout)
  );

  lq_link_ram #(
    .NUM_PTRS (NUM_PTRS)
  ) link_i (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_adr  (wr_adr),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_adr  (rd_adr),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

// File: design/lq_queue_engine.sv
`timescale 1ns/1ps
`default_nettype none

// Push and pop control around the link memory
module lq_queue_engine
  import lq_pkg::*;
(
  input  wire          clk,
  input  wire          reset,

  input  wire          push,
  input  push_req_t    pu_req,
  input  wire          pop,
  input  pop_req_t     po_req,

  // State block read ports
  output qid_t         pu_qid,
  output qid_t         po_qid,
  input  queue_state_t pu_state,
  input  queue_state_t po_state,

  // State block updates
  output logic         pu_upd,
  output qid_t         pu_upd_qid,
  output queue_state_t pu_upd_state,
  output logic         po_upd,
  output qid_t         po_upd_qid,
  output queue_state_t po_upd_state,

  // Link memory
  output logic         wr_en,
  output ptr_t         wr_adr,
  output ptr_t         wr_data,
  output logic         rd_en,
  output ptr_t         rd_adr,
  input  ptr_t         rd_data,

  output logic         pu_cvld,
  output push_rsp_t    pu_rsp,
  output logic         po_cvld,
  output pop_rsp_t     po_rsp
);

  // Pop waiting for its next head from the link memory
  logic         pend_vld;
  qid_t         pend_qid;
  qcnt_t        pend_cnt;
  ptr_t         pend_tail;
  ptr_t         pend_head;

  logic         pu_hit_pend;
  logic         po_hit_pend;
  logic         same_q;
  logic         po_take;
  qcnt_t        po_left;
  queue_state_t pu_cur;
  queue_state_t po_cur;
  queue_state_t pu_new;

  assign pu_qid = pu_req.qid;
  assign po_qid = po_req.qid;

  assign pu_hit_pend = pend_vld && (pend_qid == pu_req.qid);
  assign po_hit_pend = pend_vld && (pend_qid == po_req.qid);
  assign same_q      = push && (pu_req.qid == po_req.qid);

  // Drained queue keeps the last pointer as head
  assign pend_head = (pend_cnt != '0) ? rd_data : pend_tail;

  // State as seen this cycle, with the pending pop folded in
  always_comb begin
    pu_cur = pu_state;
    if (pu_hit_pend) begin
      pu_cur.head  = pend_head;
      pu_cur.count = pend_cnt;
    end
    po_cur = po_state;
    if (po_hit_pend) begin
      po_cur.head  = pend_head;
      po_cur.count = pend_cnt;
    end
  end

  always_comb begin
    pu_new.head  = (pu_cur.count == '0) ? pu_req.ptr : pu_cur.head;
    pu_new.tail  = pu_req.ptr;
    pu_new.count = pu_cur.count + qcnt_t'(1);
  end

  assign pu_upd       = push;
  assign pu_upd_qid   = pu_req.qid;
  assign pu_upd_state = pu_new;

  // Link old tail to the new pointer
  assign wr_en   = push && (pu_cur.count != '0);
  assign wr_adr  = pu_cur.tail;
  assign wr_data = pu_req.ptr;

  assign po_take = pop && (po_cur.count != '0);
  assign po_left = po_cur.count - qcnt_t'(1) + qcnt_t'(same_q);

  assign rd_en  = po_take && (po_left != '0);  // Only live links are read
  assign rd_adr = po_cur.head;

  always_ff @(posedge clk) begin
    if (reset) begin
      pend_vld <= 1'b0;
    end else begin
      pend_vld <= po_take;
    end
  end

  always_ff @(posedge clk) begin
    if (po_take) begin
      pend_qid  <= po_req.qid;
      pend_cnt  <= po_left;
      pend_tail <= same_q ? pu_req.ptr : po_cur.tail;
    end
  end

  // Commit of the pending head one cycle after the pop
  always_comb begin
    po_upd             = pend_vld;
    po_upd_qid         = pend_qid;
    po_upd_state.head  = pend_head;
    po_upd_state.tail  = pend_tail;
    po_upd_state.count = pend_cnt;
    if (push && pu_hit_pend && pend_cnt == '0) begin
      po_upd_state.head = pu_req.ptr;  // Refill of a just drained queue
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pu_cvld <= 1'b0;
      po_cvld <= 1'b0;
    end else begin
      pu_cvld <= push;
      po_cvld <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      pu_rsp.cnt  <= pu_new.count;
      pu_rsp.tail <= pu_cur.tail;
    end
    if (pop) begin
      po_rsp.cnt  <= po_cur.count;
      po_rsp.pvld <= po_take;
      po_rsp.ptr  <= po_cur.head;
    end
  end

  // Count includes a pop still waiting for its head
  a_push_not_full: assert property (
    @(posedge clk) disable iff (reset)
    push |-> pu_cur.count < qcnt_t'(NUM_PTRS_MAX)
  );

endmodule

`default_nettype wire

// File: design/lq_queue_state.sv
`timescale 1ns/1ps
`default_nettype none

// Head, tail and count of every queue
module lq_queue_state
  import lq_pkg::*;
#(
  parameter int NUM_QUEUES = NUM_QUEUES_MAX,
  parameter int NUM_PTRS   = NUM_PTRS_MAX
) (
  input  wire          clk,
  input  wire          reset,

  // Combinational read ports for the engine
  input  qid_t         pu_qid,
  input  qid_t         po_qid,
  output queue_state_t pu_state,
  output queue_state_t po_state,

  // Update ports from the engine
  input  wire          pu_upd,
  input  qid_t         pu_upd_qid,
  input  queue_state_t pu_upd_state,
  input  wire          po_upd,
  input  qid_t         po_upd_qid,
  input  queue_state_t po_upd_state,

  // CPU access
  input  wire          cp_read,
  input  wire          cp_write,
  input  qid_t         cp_adr,
  input  queue_state_t cp_din,
  output logic         cp_vld,
  output queue_state_t cp_dout
);

  queue_state_t q_state [NUM_QUEUES];
  queue_state_t merged;
  logic         upd_same_q;

  assign pu_state = q_state[pu_qid];
  assign po_state = q_state[po_qid];

  assign upd_same_q = pu_upd && po_upd && (pu_upd_qid == po_upd_qid);

  // Push and pop landing on one queue in the same cycle
  always_comb begin
    merged.head  = po_upd_state.head;
    merged.tail  = pu_upd_state.tail;
    merged.count = po_upd_state.count + qcnt_t'(1);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_QUEUES; i++) begin
        q_state[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_QUEUES; i++) begin
        if (cp_write && cp_adr == qid_t'(i)) begin
          q_state[i] <= cp_din;
        end else if (pu_upd && pu_upd_qid == qid_t'(i)) begin
          q_state[i] <= upd_same_q ? merged : pu_upd_state;
        end else if (po_upd && po_upd_qid == qid_t'(i)) begin
          q_state[i] <= po_upd_state;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cp_vld <= 1'b0;
    end else begin
      cp_vld <= cp_read;
    end
  end

  always_ff @(posedge clk) begin
    if (cp_read) begin
      cp_dout <= q_state[cp_adr];
    end
  end

  // CPU writes only while the engine is idle
  a_cp_write_idle: assert property (
    @(posedge clk) disable iff (reset)
    cp_write |-> !(pu_upd || po_upd)
  );

  for (genvar i = 0; i < NUM_QUEUES; i++) begin : g_count_chk
    a_count_range: assert property (
      @(posedge clk) disable iff (reset)
      q_state[i].count <= qcnt_t'(NUM_PTRS)
    );
  end

endmodule

`default_nettype wire

// File: design/lq_link_ram.sv
`timescale 1ns/1ps
`default_nettype none

// Next-pointer memory, one read and one write port
module lq_link_ram
  import lq_pkg::*;
#(
  parameter int NUM_PTRS = NUM_PTRS_MAX
) (
  input  wire  clk,

  input  wire  wr_en,
  input  ptr_t wr_adr,
  input  ptr_t wr_data,

  input  wire  rd_en,
  input  ptr_t rd_adr,
  output ptr_t rd_data
);

  ptr_t link_mem [NUM_PTRS];
  logic rd_hit_wr;

  assign rd_hit_wr = wr_en && (wr_adr == rd_adr);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      link_mem[wr_adr] <= wr_data;
    end
  end

  // Registered read; a same-address write wins
  always_ff @(posedge clk) begin
    if (rd_en) begin
      if (rd_hit_wr) begin
        rd_data <= wr_data;
      end else begin
        rd_data <= link_mem[rd_adr];
      end
    end
  end

endmodule

`default_nettype wire

// File: design/lq_pkg.sv
`default_nettype none

package lq_pkg;

  localparam int NUM_QUEUES_MAX = 8;
  localparam int NUM_PTRS_MAX   = 64;

  localparam int QID_W  = $clog2(NUM_QUEUES_MAX);
  localparam int PTR_W  = $clog2(NUM_PTRS_MAX);
  localparam int QCNT_W = PTR_W + 1;  // Holds 0 .. NUM_PTRS_MAX

  typedef logic [QID_W-1:0]  qid_t;
  typedef logic [PTR_W-1:0]  ptr_t;   // Buffer pointer and link address
  typedef logic [QCNT_W-1:0] qcnt_t;

  // Per-queue registers, also the CPU data word
  typedef struct packed {
    ptr_t  head;
    ptr_t  tail;
    qcnt_t count;
  } queue_state_t;

  typedef struct packed {
    qid_t qid;
    ptr_t ptr;
  } push_req_t;

  typedef struct packed {
    qcnt_t cnt;   // Count after the push
    ptr_t  tail;  // Previous tail
  } push_rsp_t;

  typedef struct packed {
    qid_t qid;
  } pop_req_t;

  typedef struct packed {
    qcnt_t cnt;   // Count before the pop
    logic  pvld;
    ptr_t  ptr;
  } pop_rsp_t;

endpackage

`default_nettype wire
